// ==== design/bpu_pkg.sv ====
// shared bpu types; pc fields are word addresses (pc[31:2]) unless 32 bits wide
`default_nettype none

package bpu_pkg;

	// ------------------------------
	// table geometry
	// ------------------------------
	// 64 entries, indexed by pc[7:2]
	localparam int pht_addr_width = 6;
	// tag covers pc[31:8]
	localparam int btb_tag_width  = 24;
	localparam int ras_depth      = 8;
	localparam int ras_ptr_width  = 3;

	// ------------------------------
	// decoded branch info
	// ------------------------------
	typedef enum logic [1:0] {
		kind_none,
		// b / bl, 26-bit offset
		kind_immediate,
		// jirl, rj + 16-bit offset
		kind_indirect,
		// beq..bgeu, 16-bit offset
		kind_condition
	} branch_kind_e;

	// rj compared against rd
	typedef enum logic [2:0] {
		eq,
		ne,
		lt,
		gt,
		le,
		ge,
		ltu,
		geu
	} cmp_op_e;

	// stored in the btb, steers the ras
	typedef enum logic [1:0] {
		cls_pc_relative,
		cls_absolute,
		cls_call,
		cls_return
	} br_class_e;

	// ------------------------------
	// pipeline structs
	// ------------------------------
	// travels with the instruction from fetch to execute
	typedef struct packed {
		logic                     taken;
		logic [29:0]              npc;
		br_class_e                br_class;
		logic [ras_ptr_width-1:0] ras_ptr;
		logic [1:0]               counter;
	} bpu_pred_t;

	// execute stage view of a branch
	typedef struct packed {
		logic         valid;
		logic [31:0]  pc;
		logic [31:0]  rj;
		logic [31:0]  rd;
		branch_kind_e kind;
		cmp_op_e      cmp;
		// raw instruction bits 25:0
		logic [25:0]  offs;
		logic [4:0]   rj_idx;
		logic [4:0]   rd_idx;
		// set for bl
		logic         link;
	} bpu_exec_t;

	// resolve feedback to tables, ras and stats
	typedef struct packed {
		logic                     flush;
		logic [31:0]              br_target;
		logic                     br_taken;
		logic [29:0]              pc;
		br_class_e                br_class;
		logic                     btb_update;
		logic                     pht_update;
		// counter value seen at fetch
		logic [1:0]               counter;
		logic [ras_ptr_width-1:0] ras_ptr;
		logic                     ras_restore;
	} bpu_update_t;

endpackage : bpu_pkg

`default_nettype wire

// ==== design/bpu_predict.sv ====
// lookup registered one cycle; a write and a lookup on the same entry see the old data
`timescale 1ns/1ps
`default_nettype none

module bpu_predict import bpu_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     fetch_valid_i,
	input  logic [31:0]              fetch_pc_i,
	input  logic                     enable_i,
	input  logic [29:0]              ras_top_i,
	input  logic [ras_ptr_width-1:0] ras_ptr_i,
	input  bpu_update_t              update_i,
	output logic                     pred_valid_o,
	output bpu_pred_t                pred_o
);

	localparam int entries = 1 << pht_addr_width;

	// btb arrays, no reset except valid
	logic [btb_tag_width-1:0] tag_mem [entries];
	logic [29:0]              target_mem [entries];
	br_class_e                class_mem [entries];
	logic [1:0]               pht_mem [entries];
	logic [entries-1:0]       valid_q;

	// lookup stage registers
	logic                     pred_valid_q;
	logic [29:0]              lk_pc_q;
	logic [btb_tag_width-1:0] lk_tag_q;
	logic [29:0]              lk_target_q;
	br_class_e                lk_class_q;
	logic                     lk_valid_q;
	logic [1:0]               lk_cnt_q;

	logic [pht_addr_width-1:0] lk_idx;
	logic [pht_addr_width-1:0] upd_idx;
	logic [btb_tag_width-1:0]  upd_tag;
	logic                      upd_hit;
	logic [1:0]                upd_cnt;
	logic                      lk_hit;
	logic                      lk_strong;

	// ------------------------------
	// lookup
	// ------------------------------
	assign lk_idx = fetch_pc_i[pht_addr_width+1:2];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pred_valid_q <= 1'b0;
		end else begin
			pred_valid_q <= fetch_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid_i) begin
			lk_pc_q     <= fetch_pc_i[31:2];
			lk_tag_q    <= tag_mem[lk_idx];
			lk_target_q <= target_mem[lk_idx];
			lk_class_q  <= class_mem[lk_idx];
			lk_valid_q  <= valid_q[lk_idx];
			lk_cnt_q    <= pht_mem[lk_idx];
		end
	end

	assign lk_hit = lk_valid_q && (lk_tag_q == lk_pc_q[29:pht_addr_width]);
	// unconditional kinds are taken regardless of counter
	assign lk_strong = lk_cnt_q[1] || (lk_class_q != cls_pc_relative);

	always_comb begin
		pred_o.taken    = enable_i && lk_hit && lk_strong;
		pred_o.br_class = lk_class_q;
		pred_o.ras_ptr  = ras_ptr_i;
		pred_o.counter  = lk_cnt_q;
		if (!pred_o.taken) begin
			pred_o.npc = lk_pc_q + 30'd1;
		end else if (lk_class_q == cls_return) begin
			// return target from ras top
			pred_o.npc = ras_top_i;
		end else begin
			pred_o.npc = lk_target_q;
		end
	end

	assign pred_valid_o = pred_valid_q;

	// ------------------------------
	// table update
	// ------------------------------
	assign upd_idx = update_i.pc[pht_addr_width-1:0];
	assign upd_tag = update_i.pc[29:pht_addr_width];
	assign upd_hit = valid_q[upd_idx] && (tag_mem[upd_idx] == upd_tag);

	// new entry starts weakly not taken
	always_comb begin
		if (!upd_hit) begin
			upd_cnt = 2'd1;
		end else if (update_i.br_taken) begin
			upd_cnt = (update_i.counter == 2'd3) ? 2'd3 : update_i.counter + 2'd1;
		end else begin
			upd_cnt = (update_i.counter == 2'd0) ? 2'd0 : update_i.counter - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (update_i.btb_update) begin
			valid_q[upd_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (update_i.btb_update) begin
			tag_mem[upd_idx]    <= upd_tag;
			target_mem[upd_idx] <= update_i.br_target[31:2];
			class_mem[upd_idx]  <= update_i.br_class;
		end
		// counters only for entries held in the btb
		if (update_i.pht_update && (upd_hit || update_i.btb_update)) begin
			pht_mem[upd_idx] <= upd_cnt;
		end
	end

endmodule : bpu_predict

`default_nettype wire

// ==== design/bpu_ras.sv ====
// resolved-state return stack; overflow wraps and overwrites the oldest entry
`timescale 1ns/1ps
`default_nettype none

module bpu_ras import bpu_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_i,
	input  bpu_update_t              update_i,
	input  logic [29:0]              link_i,
	output logic [29:0]              top_o,
	output logic [ras_ptr_width-1:0] ptr_o
);

	logic [29:0]              stack_mem [ras_depth];
	logic [ras_ptr_width-1:0] ptr_q;
	logic [ras_ptr_width-1:0] ptr_next;
	logic                     push;
	logic                     pop;

	// pht_update marks a resolved, non-stalled branch
	assign push = update_i.pht_update && (update_i.br_class == cls_call);
	assign pop  = update_i.pht_update && (update_i.br_class == cls_return);

	// restore already carries the +1/-1 for call/return
	always_comb begin
		if (update_i.ras_restore) begin
			ptr_next = update_i.ras_ptr;
		end else if (push) begin
			ptr_next = ptr_q + 1'b1;
		end else if (pop) begin
			ptr_next = ptr_q - 1'b1;
		end else begin
			ptr_next = ptr_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ptr_q <= '0;
		end else begin
			ptr_q <= ptr_next;
		end
	end

	// link lands in the slot the pointer moves to
	always_ff @(posedge clk) begin
		if (push) begin
			stack_mem[ptr_next] <= link_i;
		end
	end

	assign top_o = stack_mem[ptr_q];
	assign ptr_o = ptr_q;

endmodule : bpu_ras

`default_nettype wire

// ==== design/bpu_resolve.sv ====
// purely combinational; exec_i must be held by the pipeline while stall_i is high
`timescale 1ns/1ps
`default_nettype none

module bpu_resolve import bpu_pkg::*; (
	input  bpu_exec_t   exec_i,
	input  bpu_pred_t   pred_i,
	input  logic        stall_i,
	input  logic        csr_flush_i,
	input  logic [31:0] csr_target_i,
	output bpu_update_t update_o,
	output logic [31:0] link_o
);

	logic [31:0] offs26_ext;
	logic [31:0] offs16_ext;
	logic [31:0] target;
	logic [31:0] pred_npc;
	logic        taken;
	logic        dir_miss;
	logic        tgt_miss;
	logic        resolved;
	br_class_e   br_class;

	// ------------------------------
	// offsets
	// ------------------------------
	// b/bl keeps offs[15:0] in bits 25:10 and offs[25:16] in bits 9:0
	assign offs26_ext = {{4{exec_i.offs[9]}}, exec_i.offs[9:0], exec_i.offs[25:10], 2'b00};
	assign offs16_ext = {{14{exec_i.offs[25]}}, exec_i.offs[25:10], 2'b00};

	// ------------------------------
	// direction
	// ------------------------------
	always_comb begin
		case (exec_i.kind)
			kind_condition: begin
				case (exec_i.cmp)
					eq:      taken = exec_i.rj == exec_i.rd;
					ne:      taken = exec_i.rj != exec_i.rd;
					lt:      taken = $signed(exec_i.rj) < $signed(exec_i.rd);
					gt:      taken = $signed(exec_i.rj) > $signed(exec_i.rd);
					le:      taken = $signed(exec_i.rj) <= $signed(exec_i.rd);
					ge:      taken = $signed(exec_i.rj) >= $signed(exec_i.rd);
					ltu:     taken = exec_i.rj < exec_i.rd;
					default: taken = exec_i.rj >= exec_i.rd;
				endcase
			end
			kind_none: taken = 1'b0;
			// jumps always go
			default:   taken = 1'b1;
		endcase
	end

	// ------------------------------
	// target
	// ------------------------------
	always_comb begin
		if (!taken) begin
			target = link_o;
		end else if (exec_i.kind == kind_immediate) begin
			target = exec_i.pc + offs26_ext;
		end else if (exec_i.kind == kind_indirect) begin
			target = exec_i.rj + offs16_ext;
		end else begin
			target = exec_i.pc + offs16_ext;
		end
	end

	assign link_o = {exec_i.pc[31:2] + 30'd1, 2'b00};

	// ------------------------------
	// classification
	// ------------------------------
	always_comb begin
		if ((exec_i.kind == kind_indirect && exec_i.rd_idx == 5'd1) || exec_i.link) begin
			br_class = cls_call;
		end else if (exec_i.kind == kind_indirect && exec_i.rj_idx == 5'd1 &&
				offs16_ext == 32'd0) begin
			br_class = cls_return;
		end else if (exec_i.kind == kind_immediate || exec_i.kind == kind_indirect) begin
			br_class = cls_absolute;
		end else begin
			br_class = cls_pc_relative;
		end
	end

	// ------------------------------
	// miss and update
	// ------------------------------
	assign pred_npc = {pred_i.npc, 2'b00};
	assign dir_miss = pred_i.taken != taken;
	// target only matters when both sides went taken
	assign tgt_miss = pred_i.taken && taken && (pred_npc != target);

	// a csr redirect cancels training of the instruction in execute
	assign resolved = exec_i.valid && (exec_i.kind != kind_none) && !stall_i && !csr_flush_i;

	always_comb begin
		update_o.flush       = (exec_i.valid && !stall_i && (dir_miss || tgt_miss)) ||
				csr_flush_i;
		update_o.br_target   = csr_flush_i ? csr_target_i : target;
		update_o.br_taken    = taken;
		update_o.pc          = exec_i.pc[31:2];
		update_o.br_class    = br_class;
		update_o.btb_update  = resolved && taken;
		update_o.pht_update  = resolved;
		update_o.counter     = pred_i.counter;
		update_o.ras_restore = update_o.flush;
		// pointer as it stands after this branch
		case (br_class)
			cls_call:   update_o.ras_ptr = pred_i.ras_ptr + 1'b1;
			cls_return: update_o.ras_ptr = pred_i.ras_ptr - 1'b1;
			default:    update_o.ras_ptr = pred_i.ras_ptr;
		endcase
	end

endmodule : bpu_resolve

`default_nettype wire

// ==== design/bpu_csr.sv ====
// four-phase port; requester must keep req, we, addr and wdata stable until ack
`timescale 1ns/1ps
`default_nettype none

module bpu_csr import bpu_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        cfg_req_i,
	input  logic        cfg_we_i,
	input  logic [1:0]  cfg_addr_i,
	input  logic [31:0] cfg_wdata_i,
	output logic        cfg_ack_o,
	output logic [31:0] cfg_rdata_o,
	input  bpu_update_t update_i,
	input  logic        csr_flush_i,
	output logic        enable_o
);

	typedef enum logic {
		st_idle,
		st_ack
	} csr_state_e;

	csr_state_e  state_q;
	logic        enable_q;
	logic [31:0] br_cnt_q;
	logic [31:0] miss_cnt_q;
	logic [31:0] rdata_q;
	logic        access;

	// one access per handshake, taken when req is first seen
	assign access = (state_q == st_idle) && cfg_req_i;

	// ------------------------------
	// handshake
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: if (cfg_req_i) state_q <= st_ack;
				default: if (!cfg_req_i) state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (access && !cfg_we_i) begin
			case (cfg_addr_i)
				2'd0:    rdata_q <= {31'd0, enable_q};
				2'd1:    rdata_q <= br_cnt_q;
				2'd2:    rdata_q <= miss_cnt_q;
				default: rdata_q <= 32'd0;
			endcase
		end
	end

	// ------------------------------
	// registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			enable_q   <= 1'b1;
			br_cnt_q   <= '0;
			miss_cnt_q <= '0;
		end else begin
			if (access && cfg_we_i && cfg_addr_i == 2'd0) enable_q <= cfg_wdata_i[0];
			// clear wins over a same-cycle increment
			if (access && cfg_we_i && cfg_addr_i == 2'd1) begin
				br_cnt_q <= '0;
			end else if (update_i.pht_update) begin
				br_cnt_q <= br_cnt_q + 32'd1;
			end
			// csr redirects are not mispredicts
			if (access && cfg_we_i && cfg_addr_i == 2'd2) begin
				miss_cnt_q <= '0;
			end else if (update_i.flush && !csr_flush_i) begin
				miss_cnt_q <= miss_cnt_q + 32'd1;
			end
		end
	end

	assign cfg_ack_o   = state_q == st_ack;
	assign cfg_rdata_o = rdata_q;
	assign enable_o    = enable_q;

endmodule : bpu_csr

`default_nettype wire

// ==== design/bpu_top.sv ====
// single-issue fetch; pred_o valid one cycle after fetch_valid_i, redirect same cycle
`timescale 1ns/1ps
`default_nettype none

module bpu_top import bpu_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,
	// fetch
	input  logic        fetch_valid_i,
	input  logic [31:0] fetch_pc_i,
	output logic        pred_valid_o,
	output bpu_pred_t   pred_o,
	// execute
	input  bpu_exec_t   exec_i,
	input  bpu_pred_t   pred_in_i,
	input  logic        stall_i,
	input  logic        csr_flush_i,
	input  logic [31:0] csr_target_i,
	output logic        flush_o,
	output logic [31:0] target_o,
	output logic [31:0] link_o,
	// config port
	input  logic        cfg_req_i,
	input  logic        cfg_we_i,
	input  logic [1:0]  cfg_addr_i,
	input  logic [31:0] cfg_wdata_i,
	output logic        cfg_ack_o,
	output logic [31:0] cfg_rdata_o
);

	bpu_update_t              update;
	logic                     enable;
	logic [29:0]              ras_top;
	logic [ras_ptr_width-1:0] ras_ptr;

	bpu_predict u_predict (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_valid_i(fetch_valid_i),
		.fetch_pc_i   (fetch_pc_i),
		.enable_i     (enable),
		.ras_top_i    (ras_top),
		.ras_ptr_i    (ras_ptr),
		.update_i     (update),
		.pred_valid_o (pred_valid_o),
		.pred_o       (pred_o)
	);

	// link pushed as a word address
	bpu_ras u_ras (
		.clk     (clk),
		.rst_i   (rst_i),
		.update_i(update),
		.link_i  (link_o[31:2]),
		.top_o   (ras_top),
		.ptr_o   (ras_ptr)
	);

	bpu_resolve u_resolve (
		.exec_i      (exec_i),
		.pred_i      (pred_in_i),
		.stall_i     (stall_i),
		.csr_flush_i (csr_flush_i),
		.csr_target_i(csr_target_i),
		.update_o    (update),
		.link_o      (link_o)
	);

	bpu_csr u_csr (
		.clk        (clk),
		.rst_i      (rst_i),
		.cfg_req_i  (cfg_req_i),
		.cfg_we_i   (cfg_we_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_ack_o  (cfg_ack_o),
		.cfg_rdata_o(cfg_rdata_o),
		.update_i   (update),
		.csr_flush_i(csr_flush_i),
		.enable_o   (enable)
	);

	// redirect straight from resolve
	assign flush_o  = update.flush;
	assign target_o = update.br_target;

endmodule : bpu_top

`default_nettype wire

// ==== tests/bpu_checker.sv ====
// bound to bpu_top; all rules sampled on the rising clock edge and ignored during reset
`timescale 1ns/1ps
`default_nettype none

module bpu_checker import bpu_pkg::*; (
	input logic                     clk,
	input logic                     rst_i,
	input logic                     fetch_valid_i,
	input logic                     pred_valid_i,
	input logic                     stall_i,
	input logic                     csr_flush_i,
	input logic                     flush_i,
	input logic                     cfg_req_i,
	input logic                     cfg_ack_i,
	input logic [ras_ptr_width-1:0] ras_ptr_i,
	input bpu_update_t              update_i
);

	// ------------------------------
	// cfg handshake
	// ------------------------------
	ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
		$rose(cfg_ack_i) |-> $past(cfg_req_i))
		else $error("cfg ack rose without a pending request");

	// ------------------------------
	// pipeline rules
	// ------------------------------
	// a stall holds the redirect unless the csr side forces one
	stall_blocks_flush: assert property (@(posedge clk) disable iff (rst_i)
		(stall_i && !csr_flush_i) |-> !flush_i)
		else $error("flush raised while execute was stalled");

	// registered lookup, one cycle
	pred_follows_fetch: assert property (@(posedge clk) disable iff (rst_i)
		pred_valid_i == $past(fetch_valid_i))
		else $error("prediction valid did not follow fetch valid by one cycle");

	// pointer moves only from a resolved branch or a restore
	ras_ptr_moves: assert property (@(posedge clk) disable iff (rst_i)
		(ras_ptr_i != $past(ras_ptr_i)) |->
		$past(update_i.pht_update || update_i.ras_restore))
		else $error("return stack pointer moved without an update");

endmodule : bpu_checker

`default_nettype wire

// ==== tests/bpu_tb.sv ====
// drives bpu_top directly at fetch, execute and cfg ports; waits are bounded to 20 cycles
`timescale 1ns/1ps
`default_nettype none

module bpu_tb import bpu_pkg::*; ();

	// one table row; tgt is the target when taken
	typedef struct packed {
		branch_kind_e kind;
		cmp_op_e      cmp;
		logic         rnd;
		logic [31:0]  pc;
		logic [31:0]  rj;
		logic [31:0]  rd;
		logic [25:0]  offs;
		logic [4:0]   rj_idx;
		logic [4:0]   rd_idx;
		logic         exp_taken;
		logic [31:0]  tgt;
		logic         exp_flush;
	} row_t;

	logic        clk = 1'b0;
	logic        rst_i;
	logic        fetch_valid_i;
	logic [31:0] fetch_pc_i;
	logic        pred_valid_o;
	bpu_pred_t   pred_o;
	bpu_exec_t   exec_i;
	bpu_pred_t   pred_in_i;
	logic        stall_i;
	logic        csr_flush_i;
	logic [31:0] csr_target_i;
	logic        flush_o;
	logic [31:0] target_o;
	logic [31:0] link_o;
	logic        cfg_req_i;
	logic        cfg_we_i;
	logic [1:0]  cfg_addr_i;
	logic [31:0] cfg_wdata_i;
	logic        cfg_ack_o;
	logic [31:0] cfg_rdata_o;

	row_t        rows[$];
	string       row_name[$];
	row_t        r;
	bpu_exec_t   e;
	bpu_pred_t   pred;
	bpu_pred_t   no_pred;
	logic [31:0] lfsr = 32'h0d00_d6aa;
	logic [31:0] rd_val;
	logic [31:0] exp_tgt;
	logic        obs_flush;
	logic [31:0] obs_target;
	logic [31:0] obs_link;
	logic [1:0]  model_cnt;
	logic        model_valid;
	logic        model_taken;
	string       tname;
	int          exp_br;
	int          exp_miss;
	int          errors = 0;
	int          timeouts = 0;
	int          wait_limit = 20;

	bpu_top bpu_top_i (.*);

	bind bpu_top bpu_checker u_checker (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_valid_i(fetch_valid_i),
		.pred_valid_i (pred_valid_o),
		.stall_i      (stall_i),
		.csr_flush_i  (csr_flush_i),
		.flush_i      (flush_o),
		.cfg_req_i    (cfg_req_i),
		.cfg_ack_i    (cfg_ack_o),
		.ras_ptr_i    (ras_ptr),
		.update_i     (update)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------
	// right-shift galois form with one step per bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic rand_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	// rj against rd
	function automatic logic cmp_expect(input cmp_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		logic u_lt;
		logic s_lt;
		u_lt = a < b;
		// differing sign bits settle signed order on their own
		s_lt = (a[31] != b[31]) ? a[31] : u_lt;
		case (op)
			eq:      return a == b;
			ne:      return !(a == b);
			lt:      return s_lt;
			gt:      return !s_lt && (a != b);
			le:      return s_lt || (a == b);
			ge:      return !s_lt;
			ltu:     return u_lt;
			default: return !u_lt;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic add_row(input string name, input branch_kind_e kind, input cmp_op_e cmp,
			input logic rnd, input logic [31:0] pc, input logic [31:0] rj,
			input logic [31:0] rd, input logic [25:0] offs, input logic taken,
			input logic [31:0] tgt);
		row_t t;
		t = '{kind: kind, cmp: cmp, rnd: rnd, pc: pc, rj: rj, rd: rd, offs: offs,
			rj_idx: 5'd4, rd_idx: 5'd5, exp_taken: taken, tgt: tgt, exp_flush: taken};
		rows.push_back(t);
		row_name.push_back(name);
	endtask

	// one full four-phase access
	task automatic cfg_access(input logic we, input logic [1:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		@(posedge clk);
		cfg_req_i   <= 1'b1;
		cfg_we_i    <= we;
		cfg_addr_i  <= addr;
		cfg_wdata_i <= wdata;
		for (n = 0; n < wait_limit; n++) begin
			@(negedge clk);
			if (cfg_ack_o) break;
		end
		if (n == wait_limit) begin
			timeouts++;
			$display("timeout: cfg ack never rose for address %0d", addr);
		end
		rdata = cfg_rdata_o;
		@(posedge clk);
		cfg_req_i <= 1'b0;
		for (n = 0; n < wait_limit; n++) begin
			@(negedge clk);
			if (!cfg_ack_o) break;
		end
		if (n == wait_limit) begin
			timeouts++;
			$display("timeout: cfg ack stayed high after the request dropped");
		end
	endtask

	task automatic lookup(input logic [31:0] pc, output bpu_pred_t p);
		int n;
		@(posedge clk);
		fetch_valid_i <= 1'b1;
		fetch_pc_i    <= pc;
		@(posedge clk);
		fetch_valid_i <= 1'b0;
		for (n = 0; n < wait_limit; n++) begin
			@(negedge clk);
			if (pred_valid_o) break;
		end
		if (n == wait_limit) begin
			timeouts++;
			$display("timeout: no prediction came back for pc %h", pc);
		end
		p = pred_o;
	endtask

	// redirect is combinational and sampled mid-cycle; tables train on the next edge
	task automatic apply_exec(input bpu_exec_t x, input bpu_pred_t p);
		@(posedge clk);
		exec_i    <= x;
		pred_in_i <= p;
		@(negedge clk);
		obs_flush  = flush_o;
		obs_target = target_o;
		obs_link   = link_o;
		@(posedge clk);
		exec_i <= '0;
	endtask

	// ------------------------------
	// sequence
	// ------------------------------
	initial begin
		rst_i         <= 1'b1;
		fetch_valid_i <= 1'b0;
		fetch_pc_i    <= '0;
		exec_i        <= '0;
		pred_in_i     <= '0;
		stall_i       <= 1'b0;
		csr_flush_i   <= 1'b0;
		csr_target_i  <= '0;
		cfg_req_i     <= 1'b0;
		cfg_we_i      <= 1'b0;
		cfg_addr_i    <= '0;
		cfg_wdata_i   <= '0;
		no_pred = '0;
		exp_br = 0;
		exp_miss = 0;
		repeat (8) @(posedge clk);
		rst_i <= 1'b0;

		// eight compares plus both jumps and one non-branch
		add_row("beq", kind_condition, eq, 1'b0, 32'h1000, 5, 5, 26'h0004000, 1'b1, 32'h1040);
		add_row("bne", kind_condition, ne, 1'b0, 32'h1004, 5, 5, 26'h0004000, 1'b0, 32'h1044);
		add_row("blt", kind_condition, lt, 1'b0, 32'h1008, 32'hffff_fffd, 2, 26'h0004000,
			1'b1, 32'h1048);
		add_row("bgt", kind_condition, gt, 1'b0, 32'h100c, 32'hffff_fffd, 2, 26'h0004000,
			1'b0, 32'h104c);
		add_row("ble", kind_condition, le, 1'b0, 32'h1010, 7, 7, 26'h3ffc000, 1'b1, 32'h0fd0);
		add_row("bge", kind_condition, ge, 1'b0, 32'h1014, 2, 32'hffff_fffd, 26'h0004000,
			1'b1, 32'h1054);
		add_row("bltu", kind_condition, ltu, 1'b0, 32'h1018, 32'hffff_fffd, 2, 26'h0004000,
			1'b0, 32'h1058);
		add_row("bgeu", kind_condition, geu, 1'b0, 32'h101c, 32'hffff_fffd, 2, 26'h0004000,
			1'b1, 32'h105c);
		add_row("lt_rnd", kind_condition, lt, 1'b1, 32'h1020, 0, 0, 26'h0004000, 1'b0, 32'h1060);
		add_row("gt_rnd", kind_condition, gt, 1'b1, 32'h1024, 0, 0, 26'h0004000, 1'b0, 32'h1064);
		add_row("ltu_rnd", kind_condition, ltu, 1'b1, 32'h1028, 0, 0, 26'h0004000, 1'b0,
			32'h1068);
		add_row("geu_rnd", kind_condition, geu, 1'b1, 32'h102c, 0, 0, 26'h0004000, 1'b0,
			32'h106c);
		// b keeps offs[15:0] in 25:10 and offs[25:16] in 9:0
		add_row("b_fwd", kind_immediate, eq, 1'b0, 32'h1030, 0, 0, 26'h0010000, 1'b1, 32'h1130);
		add_row("b_back", kind_immediate, eq, 1'b0, 32'h1034, 0, 0, 26'h3ffc3ff, 1'b1, 32'h0ff4);
		add_row("jirl", kind_indirect, eq, 1'b0, 32'h1038, 32'h8000, 0, 26'h0004000, 1'b1,
			32'h8040);
		add_row("none", kind_none, eq, 1'b0, 32'h103c, 0, 0, 26'h0000000, 1'b0, 32'h0);

		// ------------------------------
		// direction and target with predictor off
		// ------------------------------
		cfg_access(1'b1, 2'd0, 32'd0, rd_val);
		cfg_access(1'b0, 2'd0, 32'd0, rd_val);
		check_word("ctrl after disable", 32'd0, rd_val);
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			if (r.rnd) begin
				rand_word(r.rj);
				rand_word(r.rd);
				r.exp_taken = cmp_expect(r.cmp, r.rj, r.rd);
				r.exp_flush = r.exp_taken;
			end
			exp_tgt = r.exp_taken ? r.tgt : r.pc + 32'd4;
			e = '0;
			e.valid  = 1'b1;
			e.pc     = r.pc;
			e.rj     = r.rj;
			e.rd     = r.rd;
			e.kind   = r.kind;
			e.cmp    = r.cmp;
			e.offs   = r.offs;
			e.rj_idx = r.rj_idx;
			e.rd_idx = r.rd_idx;
			apply_exec(e, no_pred);
			check_bit({row_name[i], " flush"}, r.exp_flush, obs_flush);
			check_word({row_name[i], " target"}, exp_tgt, obs_target);
			if (r.kind != kind_none) begin
				exp_br++;
			end
			if (r.exp_flush) begin
				exp_miss++;
			end
		end

		// ------------------------------
		// statistics
		// ------------------------------
		cfg_access(1'b0, 2'd1, 32'd0, rd_val);
		check_word("branch count", exp_br, rd_val);
		cfg_access(1'b0, 2'd2, 32'd0, rd_val);
		check_word("miss count", exp_miss, rd_val);
		cfg_access(1'b1, 2'd1, 32'd0, rd_val);
		cfg_access(1'b1, 2'd2, 32'd0, rd_val);
		cfg_access(1'b0, 2'd1, 32'd0, rd_val);
		check_word("branch count cleared", 32'd0, rd_val);
		cfg_access(1'b0, 2'd2, 32'd0, rd_val);
		check_word("miss count cleared", 32'd0, rd_val);
		exp_br = 0;
		exp_miss = 0;

		// ------------------------------
		// training on an always-taken beq
		// ------------------------------
		cfg_access(1'b1, 2'd0, 32'd1, rd_val);
		e = '0;
		e.valid  = 1'b1;
		e.kind   = kind_condition;
		e.cmp    = eq;
		e.pc     = 32'h3080;
		e.rj     = 32'd9;
		e.rd     = 32'd9;
		e.offs   = 26'h0004000;
		e.rj_idx = 5'd4;
		e.rd_idx = 5'd5;
		model_valid = 1'b0;
		model_cnt   = 2'd0;
		model_taken = 1'b0;
		lookup(32'h3080, pred);
		for (int pass = 1; pass <= 3; pass++) begin
			apply_exec(e, pred);
			tname = $sformatf("train pass %0d flush", pass);
			check_bit(tname, !model_taken, obs_flush);
			exp_br++;
			if (!model_taken) begin
				exp_miss++;
			end
			// new entry weakly not taken and saturating up after
			if (!model_valid) begin
				model_cnt = 2'd1;
			end else if (model_cnt != 2'd3) begin
				model_cnt = model_cnt + 2'd1;
			end
			model_valid = 1'b1;
			model_taken = model_cnt[1];
			lookup(32'h3080, pred);
			tname = $sformatf("train pass %0d pred taken", pass);
			check_bit(tname, model_taken, pred.taken);
			tname = $sformatf("train pass %0d counter", pass);
			check_word(tname, {30'd0, model_cnt}, {30'd0, pred.counter});
			if (model_taken) begin
				check_word("train pred npc", 32'h30c0, {pred.npc, 2'b00});
			end
		end

		// ------------------------------
		// call and return
		// ------------------------------
		// jirl r0, r1, 0 puts a return into the buffer
		lookup(32'h40d0, pred);
		e = '0;
		e.valid  = 1'b1;
		e.kind   = kind_indirect;
		e.pc     = 32'h40d0;
		e.rj     = 32'h4400;
		e.rj_idx = 5'd1;
		apply_exec(e, pred);
		check_bit("return flush", 1'b1, obs_flush);
		exp_br++;
		exp_miss++;
		// bl at P links P+4
		lookup(32'h40c0, pred);
		e = '0;
		e.valid  = 1'b1;
		e.kind   = kind_immediate;
		e.pc     = 32'h40c0;
		e.offs   = 26'h0010000;
		e.rd_idx = 5'd1;
		e.link   = 1'b1;
		apply_exec(e, pred);
		check_bit("bl flush", 1'b1, obs_flush);
		check_word("bl link", 32'h40c0 + 32'd4, obs_link);
		exp_br++;
		exp_miss++;
		lookup(32'h40d0, pred);
		check_bit("return pred taken", 1'b1, pred.taken);
		check_word("return pred class", {30'd0, cls_return}, {30'd0, pred.br_class});
		check_word("return pred npc", 32'h40c0 + 32'd4, {pred.npc, 2'b00});

		// ------------------------------
		// stall then csr redirect
		// ------------------------------
		e = '0;
		e.valid  = 1'b1;
		e.kind   = kind_condition;
		e.cmp    = eq;
		e.pc     = 32'h50e0;
		e.rj     = 32'd3;
		e.rd     = 32'd3;
		e.offs   = 26'h0004000;
		e.rj_idx = 5'd4;
		e.rd_idx = 5'd5;
		@(posedge clk);
		exec_i    <= e;
		pred_in_i <= no_pred;
		stall_i   <= 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_bit("stalled flush", 1'b0, flush_o);
		end
		@(posedge clk);
		csr_flush_i  <= 1'b1;
		csr_target_i <= 32'h0000_9000;
		@(negedge clk);
		check_bit("csr flush", 1'b1, flush_o);
		check_word("csr target", 32'h0000_9000, target_o);
		@(posedge clk);
		exec_i      <= '0;
		stall_i     <= 1'b0;
		csr_flush_i <= 1'b0;
		// neither the stall nor the csr redirect counts
		cfg_access(1'b0, 2'd1, 32'd0, rd_val);
		check_word("branch count after stall", exp_br, rd_val);
		cfg_access(1'b0, 2'd2, 32'd0, rd_val);
		check_word("miss count after stall", exp_miss, rd_val);

		$display("errors=%0d timeouts=%0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule : bpu_tb

`default_nettype wire

// ==== list.f ====
design/bpu_pkg.sv
design/bpu_predict.sv
design/bpu_ras.sv
design/bpu_resolve.sv
design/bpu_csr.sv
design/bpu_top.sv
tests/bpu_checker.sv
tests/bpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bpu testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module bpu_tb -o Vbpu_tb
./obj_dir/Vbpu_tb | tee sim.log
if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
exit 1
